/* lcc_config.svh */
`ifndef LCC_CONFIG_SVH
`define LCC_CONFIG_SVH

// ------------------------------------------------------------
// Life-cycle side widths
// ------------------------------------------------------------

// State code as carried on the OTP and program-request buses
`define LCC_STATE_W 5

// Debug class of a decoded static state
`define LCC_CLASS_W 3

// Multibit life-cycle enable flag
`define LCC_TX_W 4
// Only this exact pattern counts as on, every other code is off
`define LCC_TX_ON 4'b0101

// ------------------------------------------------------------
// SoC and core side widths
// ------------------------------------------------------------

// Unlock level and the three mask registers
`define LCC_UNLOCK_W 64

// Core lifecycle field and translator FSM state
`define LCC_LIFECYCLE_W 2
`define LCC_TRANS_W 3

// Debug stays locked out of reset and whenever OTP data is not valid
`define LCC_DBG_LOCKED_RST 1'b1

`endif

/* lc_state_pkg.sv */
`include "lcc_config.svh"

package lc_state_pkg;

  // ------------------------------------------------------------
  // Life-cycle state codes
  // ------------------------------------------------------------

  // RAW is all zeros so a cleared register decodes as RAW
  typedef enum logic [`LCC_STATE_W-1:0] {
    RAW = 0,
    TEST_UNLOCKED0,
    TEST_UNLOCKED1,
    TEST_UNLOCKED2,
    TEST_UNLOCKED3,
    TEST_UNLOCKED4,
    TEST_UNLOCKED5,
    TEST_UNLOCKED6,
    TEST_UNLOCKED7,
    TEST_LOCKED0,
    TEST_LOCKED1,
    TEST_LOCKED2,
    TEST_LOCKED3,
    TEST_LOCKED4,
    TEST_LOCKED5,
    TEST_LOCKED6,
    DEV,
    PROD,
    PROD_END,
    RMA,
    SCRAP
  } lc_state_e;

  // Multibit enable from the life-cycle controller
  typedef logic [`LCC_TX_W-1:0] lc_tx_t;

  // ------------------------------------------------------------
  // Debug classes
  // ------------------------------------------------------------

  // Groups of states that the translator treats the same way
  typedef enum logic [`LCC_CLASS_W-1:0] {
    CLS_LOCKED,
    CLS_TEST_UNLOCKED,
    CLS_MANUF,
    CLS_PROD,
    CLS_RMA,
    CLS_SCRAP,
    CLS_UNKNOWN
  } lc_class_e;

endpackage

/* sec_state_pkg.sv */
`include "lcc_config.svh"

package sec_state_pkg;

  // ------------------------------------------------------------
  // Core security state
  // ------------------------------------------------------------

  // Lifecycle field seen by the core
  // PRODUCTION is the safe fallback
  typedef enum logic [`LCC_LIFECYCLE_W-1:0] {
    UNPROVISIONED = 2'b00,
    MANUFACTURING = 2'b01,
    PRODUCTION    = 2'b11
  } device_lifecycle_e;

  // ------------------------------------------------------------
  // Translator FSM
  // ------------------------------------------------------------

  typedef enum logic [`LCC_TRANS_W-1:0] {
    RESET,
    IDLE,
    NON_DEBUG,
    UNPROV_DEBUG,
    MANUF_NON_DEBUG,
    MANUF_DEBUG,
    PROD_NON_DEBUG,
    PROD_DEBUG
  } trans_state_e;

  // Unlock level and mask vectors
  typedef logic [`LCC_UNLOCK_W-1:0] unlock_vec_t;

endpackage

/* lc_class_decode.sv */
`timescale 1ns/1ps

module lc_class_decode (
  // Static state held by the translator
  input  lc_state_pkg::lc_state_e otp_static_state_i,
  // Program request towards OTP
  input  logic                    lcc_prog_req_i,
  input  lc_state_pkg::lc_state_e lcc_alive_state_i,
  // Decoded class and SCRAP request
  output lc_state_pkg::lc_class_e static_class_o,
  output logic                    scrap_req_o
);

  // ------------------------------------------------------------
  // Static state to debug class
  // ------------------------------------------------------------

  always_comb begin
    // Unused codes fall through to UNKNOWN
    static_class_o = lc_state_pkg::CLS_UNKNOWN;
    case (otp_static_state_i)
      // RAW and all locked test states have no debug
      lc_state_pkg::RAW,
      lc_state_pkg::TEST_LOCKED0,
      lc_state_pkg::TEST_LOCKED1,
      lc_state_pkg::TEST_LOCKED2,
      lc_state_pkg::TEST_LOCKED3,
      lc_state_pkg::TEST_LOCKED4,
      lc_state_pkg::TEST_LOCKED5,
      lc_state_pkg::TEST_LOCKED6: begin
        static_class_o = lc_state_pkg::CLS_LOCKED;
      end
      // Unprovisioned debug
      lc_state_pkg::TEST_UNLOCKED0,
      lc_state_pkg::TEST_UNLOCKED1,
      lc_state_pkg::TEST_UNLOCKED2,
      lc_state_pkg::TEST_UNLOCKED3,
      lc_state_pkg::TEST_UNLOCKED4,
      lc_state_pkg::TEST_UNLOCKED5,
      lc_state_pkg::TEST_UNLOCKED6,
      lc_state_pkg::TEST_UNLOCKED7: begin
        static_class_o = lc_state_pkg::CLS_TEST_UNLOCKED;
      end
      // Manufacturing, unlocked later by the manuf enable
      lc_state_pkg::DEV: begin
        static_class_o = lc_state_pkg::CLS_MANUF;
      end
      // Production and its end state behave alike
      lc_state_pkg::PROD,
      lc_state_pkg::PROD_END: begin
        static_class_o = lc_state_pkg::CLS_PROD;
      end
      lc_state_pkg::RMA: begin
        static_class_o = lc_state_pkg::CLS_RMA;
      end
      lc_state_pkg::SCRAP: begin
        static_class_o = lc_state_pkg::CLS_SCRAP;
      end
      default: begin
        static_class_o = lc_state_pkg::CLS_UNKNOWN;
      end
    endcase
  end

  // ------------------------------------------------------------
  // SCRAP request
  // ------------------------------------------------------------

  // Valid only while the program request is raised
  assign scrap_req_o = lcc_prog_req_i && (lcc_alive_state_i == lc_state_pkg::SCRAP);

endmodule

/* lcc_debug_enables.sv */
`timescale 1ns/1ps
`include "lcc_config.svh"

module lcc_debug_enables (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       otp_valid_i,
  input  logic                       scrap_req_i,
  // Life-cycle multibit flags
  input  lc_state_pkg::lc_tx_t       lc_dft_en_i,
  input  lc_state_pkg::lc_tx_t       lc_hw_debug_en_i,
  // Unlock level and SoC masks
  input  sec_state_pkg::unlock_vec_t unlock_level_i,
  input  sec_state_pkg::unlock_vec_t dft_mask_i,
  input  sec_state_pkg::unlock_vec_t cltap_mask_i,
  input  sec_state_pkg::unlock_vec_t prod_unlock_mask_i,
  output logic                       soc_dft_en_o,
  output logic                       soc_hw_debug_en_o,
  output logic                       prod_unlock_o
);

  // Any overlap between level and mask
  logic dft_hit;
  logic cltap_hit;

  // Flag on or mask hit, killed by a SCRAP request
  function automatic logic enable_rule(input lc_state_pkg::lc_tx_t flag,
                                       input logic hit,
                                       input logic scrap);
    enable_rule = ((flag == `LCC_TX_ON) | hit) & ~scrap;
  endfunction

  assign dft_hit   = |(unlock_level_i & dft_mask_i);
  assign cltap_hit = |(unlock_level_i & cltap_mask_i);

  // Production unlock goes straight to the FSM
  assign prod_unlock_o = |(unlock_level_i & prod_unlock_mask_i);

  // ------------------------------------------------------------
  // Registered SoC enables
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= enable_rule(lc_dft_en_i, dft_hit, scrap_req_i);
      soc_hw_debug_en_o <= enable_rule(lc_hw_debug_en_i, cltap_hit, scrap_req_i);
    end else begin
      // No valid OTP data, keep both off
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

/* lcc_trans_fsm.sv */
`timescale 1ns/1ps
`include "lcc_config.svh"

module lcc_trans_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            otp_valid_i,
  input  lc_state_pkg::lc_state_e         otp_state_i,
  // From the decoder
  input  lc_state_pkg::lc_class_e         static_class_i,
  input  logic                            scrap_req_i,
  // SoC and core controls
  input  logic                            state_error_i,
  input  logic                            dbg_manuf_en_i,
  input  logic                            prod_unlock_i,
  // Captured static state, back to the decoder
  output lc_state_pkg::lc_state_e         otp_static_state_o,
  // Registered core security state
  output sec_state_pkg::device_lifecycle_e device_lifecycle_o,
  output logic                            debug_locked_o
);

  sec_state_pkg::trans_state_e      state_q;
  sec_state_pkg::trans_state_e      state_d;
  sec_state_pkg::device_lifecycle_e lifecycle_d;
  logic                             locked_d;
  // Any event that forces the sticky non-debug state
  logic                             escape;

  assign escape = scrap_req_i | state_error_i;

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= sec_state_pkg::RESET;
      otp_static_state_o <= lc_state_pkg::RAW;
      device_lifecycle_o <= sec_state_pkg::PRODUCTION;
      debug_locked_o     <= `LCC_DBG_LOCKED_RST;
    end else if (otp_valid_i) begin
      state_q            <= state_d;
      // Sampled every valid cycle, only IDLE looks at it
      otp_static_state_o <= otp_state_i;
      device_lifecycle_o <= lifecycle_d;
      debug_locked_o     <= locked_d;
    end else begin
      // Dropping valid restarts the whole translation
      state_q            <= sec_state_pkg::RESET;
      otp_static_state_o <= lc_state_pkg::RAW;
      device_lifecycle_o <= sec_state_pkg::PRODUCTION;
      debug_locked_o     <= `LCC_DBG_LOCKED_RST;
    end
  end

  // ------------------------------------------------------------
  // Next state and next security state
  // ------------------------------------------------------------

  always_comb begin
    // Production with debug locked unless a state below says otherwise
    state_d     = state_q;
    lifecycle_d = sec_state_pkg::PRODUCTION;
    locked_d    = `LCC_DBG_LOCKED_RST;
    case (state_q)
      sec_state_pkg::RESET: begin
        // Leave one cycle for the static state capture
        state_d = sec_state_pkg::IDLE;
      end
      sec_state_pkg::IDLE: begin
        if (escape || static_class_i == lc_state_pkg::CLS_SCRAP) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          case (static_class_i)
            lc_state_pkg::CLS_LOCKED:        state_d = sec_state_pkg::NON_DEBUG;
            lc_state_pkg::CLS_TEST_UNLOCKED: state_d = sec_state_pkg::UNPROV_DEBUG;
            lc_state_pkg::CLS_MANUF:         state_d = sec_state_pkg::MANUF_NON_DEBUG;
            lc_state_pkg::CLS_PROD:          state_d = sec_state_pkg::PROD_NON_DEBUG;
            lc_state_pkg::CLS_RMA:           state_d = sec_state_pkg::PROD_DEBUG;
            // Unknown codes wait in IDLE
            default:                         state_d = sec_state_pkg::IDLE;
          endcase
        end
      end
      sec_state_pkg::NON_DEBUG: begin
        // Sticky until valid drops
        state_d = sec_state_pkg::NON_DEBUG;
      end
      sec_state_pkg::UNPROV_DEBUG: begin
        if (escape) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          lifecycle_d = sec_state_pkg::UNPROVISIONED;
          locked_d    = 1'b0;
        end
      end
      sec_state_pkg::MANUF_NON_DEBUG: begin
        if (escape) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          // Still locked on the cycle the enable is seen
          lifecycle_d = sec_state_pkg::MANUFACTURING;
          if (dbg_manuf_en_i) begin
            state_d = sec_state_pkg::MANUF_DEBUG;
          end
        end
      end
      sec_state_pkg::MANUF_DEBUG: begin
        if (escape) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          lifecycle_d = sec_state_pkg::MANUFACTURING;
          locked_d    = 1'b0;
        end
      end
      sec_state_pkg::PROD_NON_DEBUG: begin
        if (escape) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else if (prod_unlock_i) begin
          state_d = sec_state_pkg::PROD_DEBUG;
        end
      end
      sec_state_pkg::PROD_DEBUG: begin
        if (escape) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          locked_d = 1'b0;
        end
      end
      default: begin
        state_d = sec_state_pkg::IDLE;
      end
    endcase
  end

endmodule

/* lcc_st_trans.sv */
`timescale 1ns/1ps

module lcc_st_trans (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // OTP side
  input  logic                             otp_valid_i,
  input  lc_state_pkg::lc_state_e          otp_state_i,
  input  logic                             lcc_prog_req_i,
  input  lc_state_pkg::lc_state_e          lcc_alive_state_i,
  // SoC side
  input  logic                             state_error_i,
  input  logic                             dbg_manuf_en_i,
  input  sec_state_pkg::unlock_vec_t       unlock_level_i,
  input  sec_state_pkg::unlock_vec_t       dft_mask_i,
  input  sec_state_pkg::unlock_vec_t       cltap_mask_i,
  input  sec_state_pkg::unlock_vec_t       prod_unlock_mask_i,
  // Life-cycle flags
  input  lc_state_pkg::lc_tx_t             lc_dft_en_i,
  input  lc_state_pkg::lc_tx_t             lc_hw_debug_en_i,
  // SoC enables
  output logic                             soc_dft_en_o,
  output logic                             soc_hw_debug_en_o,
  // Core security state
  output sec_state_pkg::device_lifecycle_e device_lifecycle_o,
  output logic                             debug_locked_o
);

  lc_state_pkg::lc_state_e otp_static_state;
  lc_state_pkg::lc_class_e static_class;
  logic                    scrap_req;
  logic                    prod_unlock;

  // ------------------------------------------------------------
  // State decode
  // ------------------------------------------------------------

  lc_class_decode decode_i (
    .otp_static_state_i (otp_static_state),
    .lcc_prog_req_i     (lcc_prog_req_i),
    .lcc_alive_state_i  (lcc_alive_state_i),
    .static_class_o     (static_class),
    .scrap_req_o        (scrap_req)
  );

  // ------------------------------------------------------------
  // SoC enables and production unlock match
  // ------------------------------------------------------------

  lcc_debug_enables enables_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .otp_valid_i        (otp_valid_i),
    .scrap_req_i        (scrap_req),
    .lc_dft_en_i        (lc_dft_en_i),
    .lc_hw_debug_en_i   (lc_hw_debug_en_i),
    .unlock_level_i     (unlock_level_i),
    .dft_mask_i         (dft_mask_i),
    .cltap_mask_i       (cltap_mask_i),
    .prod_unlock_mask_i (prod_unlock_mask_i),
    .soc_dft_en_o       (soc_dft_en_o),
    .soc_hw_debug_en_o  (soc_hw_debug_en_o),
    .prod_unlock_o      (prod_unlock)
  );

  // ------------------------------------------------------------
  // Translator FSM
  // ------------------------------------------------------------

  lcc_trans_fsm fsm_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .otp_valid_i        (otp_valid_i),
    .otp_state_i        (otp_state_i),
    .static_class_i     (static_class),
    .scrap_req_i        (scrap_req),
    .state_error_i      (state_error_i),
    .dbg_manuf_en_i     (dbg_manuf_en_i),
    .prod_unlock_i      (prod_unlock),
    .otp_static_state_o (otp_static_state),
    .device_lifecycle_o (device_lifecycle_o),
    .debug_locked_o     (debug_locked_o)
  );

endmodule

/* tb_lcc_checker.sv */
`timescale 1ns/1ps
`include "lcc_config.svh"

module tb_lcc_checker (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Stimulus as driven into the DUT
  input  logic                             otp_valid_i,
  input  lc_state_pkg::lc_state_e          otp_state_i,
  input  logic                             lcc_prog_req_i,
  input  lc_state_pkg::lc_state_e          lcc_alive_state_i,
  input  logic                             state_error_i,
  input  logic                             dbg_manuf_en_i,
  input  sec_state_pkg::unlock_vec_t       unlock_level_i,
  input  sec_state_pkg::unlock_vec_t       dft_mask_i,
  input  sec_state_pkg::unlock_vec_t       cltap_mask_i,
  input  sec_state_pkg::unlock_vec_t       prod_unlock_mask_i,
  input  lc_state_pkg::lc_tx_t             lc_dft_en_i,
  input  lc_state_pkg::lc_tx_t             lc_hw_debug_en_i,
  // DUT responses
  input  logic                             soc_dft_en_i,
  input  logic                             soc_hw_debug_en_i,
  input  sec_state_pkg::device_lifecycle_e device_lifecycle_i,
  input  logic                             debug_locked_i,
  output int unsigned                      error_count_o,
  output int unsigned                      check_count_o
);

  // Valid edges in a row, and edges since the unlock or escape inputs changed
  int unsigned             valid_cnt;
  int unsigned             sec_stable;
  logic [2:0]              sec_prev;
  logic [2:0]              sec_now;
  // Static state as captured on the first valid edge
  lc_state_pkg::lc_state_e static_cap;
  // Sticky events taken by the FSM since valid rose
  logic                    manuf_seen;
  logic                    prod_seen;
  logic                    escaped;
  logic                    scrap_req;
  logic                    prod_match;
  // Expected values of the outputs registered on the last edge
  logic                    exp_dft;
  logic                    exp_hw;
  logic [2:0]              exp_sec;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Returns {lifecycle, debug_locked} once the translation has settled
  function automatic logic [2:0] expected_security(input lc_state_pkg::lc_state_e st,
                                                   input logic manuf_unlocked,
                                                   input logic prod_unlocked,
                                                   input logic escape_taken);
    logic [1:0] lc;
    logic       locked;
    lc     = sec_state_pkg::PRODUCTION;
    locked = 1'b1;
    if (!escape_taken) begin
      if (st >= lc_state_pkg::TEST_UNLOCKED0 && st <= lc_state_pkg::TEST_UNLOCKED7) begin
        lc     = sec_state_pkg::UNPROVISIONED;
        locked = 1'b0;
      end else if (st == lc_state_pkg::DEV) begin
        lc     = sec_state_pkg::MANUFACTURING;
        locked = !manuf_unlocked;
      end else if (st == lc_state_pkg::PROD || st == lc_state_pkg::PROD_END) begin
        locked = !prod_unlocked;
      end else if (st == lc_state_pkg::RMA) begin
        locked = 1'b0;
      end
    end
    return {lc, locked};
  endfunction

  // SoC enable: flag on or level hits mask, never during a SCRAP request
  function automatic logic enable_expected(input lc_state_pkg::lc_tx_t flag,
                                           input sec_state_pkg::unlock_vec_t level,
                                           input sec_state_pkg::unlock_vec_t mask,
                                           input logic scrap);
    if (scrap) begin
      return 1'b0;
    end
    if (flag == `LCC_TX_ON) begin
      return 1'b1;
    end
    return (level & mask) != '0;
  endfunction

  task automatic compare_bits(input string what, input logic [1:0] got,
                              input logic [1:0] expv);
    check_count_o++;
    if (got !== expv) begin
      error_count_o++;
      $display("[FAIL] %0t: %s is %0d, expected %0d (static state %s)",
               $time, what, got, expv, static_cap.name());
    end
  endtask

  // ------------------------------------------------------------
  // Comparison on every rising edge
  // ------------------------------------------------------------

  always @(posedge clk_i) begin
    scrap_req  = lcc_prog_req_i && (lcc_alive_state_i == lc_state_pkg::SCRAP);
    prod_match = (unlock_level_i & prod_unlock_mask_i) != '0;
    sec_now    = {dbg_manuf_en_i, prod_match, scrap_req | state_error_i};
    if (!rst_ni) begin
      error_count_o = 0;
      check_count_o = 0;
      valid_cnt     = 0;
      sec_stable    = 0;
      sec_prev      = sec_now;
      static_cap    = lc_state_pkg::RAW;
      manuf_seen    = 1'b0;
      prod_seen     = 1'b0;
      escaped       = 1'b0;
      exp_dft       = 1'b0;
      exp_hw        = 1'b0;
    end else begin
      // Outputs seen here come from the previous edge
      compare_bits("soc_dft_en", {1'b0, soc_dft_en_i}, {1'b0, exp_dft});
      compare_bits("soc_hw_debug_en", {1'b0, soc_hw_debug_en_i}, {1'b0, exp_hw});
      // Security state is reset-like until the third valid edge, then settles in two
      if (valid_cnt < 3 || sec_stable >= 2) begin
        if (valid_cnt < 3) begin
          exp_sec = {sec_state_pkg::PRODUCTION, 1'b1};
        end else begin
          exp_sec = expected_security(static_cap, manuf_seen, prod_seen, escaped);
        end
        compare_bits("device_lifecycle", device_lifecycle_i, exp_sec[2:1]);
        compare_bits("debug_locked", {1'b0, debug_locked_i}, {1'b0, exp_sec[0]});
      end
      // Track what the DUT samples on this edge
      if (otp_valid_i) begin
        valid_cnt++;
        if (valid_cnt == 1) begin
          static_cap = otp_state_i;
        end
        // IDLE and later states react to an escape
        if (valid_cnt >= 2 && sec_now[0]) begin
          escaped = 1'b1;
        end
        // Unlocks only count once the FSM has left IDLE
        if (valid_cnt >= 3 && dbg_manuf_en_i) begin
          manuf_seen = 1'b1;
        end
        if (valid_cnt >= 3 && prod_match) begin
          prod_seen = 1'b1;
        end
        exp_dft = enable_expected(lc_dft_en_i, unlock_level_i, dft_mask_i, scrap_req);
        exp_hw  = enable_expected(lc_hw_debug_en_i, unlock_level_i, cltap_mask_i, scrap_req);
      end else begin
        valid_cnt  = 0;
        manuf_seen = 1'b0;
        prod_seen  = 1'b0;
        escaped    = 1'b0;
        exp_dft    = 1'b0;
        exp_hw     = 1'b0;
      end
      if (sec_now == sec_prev) begin
        sec_stable++;
      end else begin
        sec_stable = 1;
      end
      sec_prev = sec_now;
    end
  end

endmodule

/* tb_lcc_st_trans.sv */
`timescale 1ns/1ps
`include "lcc_config.svh"

module tb_lcc_st_trans;

  // Cycle budget, one bring-up takes 7 cycles
  localparam int unsigned UP_CYC = 7;
  localparam int unsigned MAX_CYCLES = 3 + 21 * UP_CYC + 4 * (UP_CYC + 8) + (UP_CYC + 80)
                                       + 8 * (UP_CYC + 11) + 2 * UP_CYC + 11 + 50;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             otp_valid_i;
  logic                             lcc_prog_req_i;
  logic                             state_error_i;
  logic                             dbg_manuf_en_i;
  lc_state_pkg::lc_state_e          otp_state_i;
  lc_state_pkg::lc_state_e          lcc_alive_state_i;
  lc_state_pkg::lc_tx_t             lc_dft_en_i;
  lc_state_pkg::lc_tx_t             lc_hw_debug_en_i;
  sec_state_pkg::unlock_vec_t       unlock_level_i;
  sec_state_pkg::unlock_vec_t       dft_mask_i;
  sec_state_pkg::unlock_vec_t       cltap_mask_i;
  sec_state_pkg::unlock_vec_t       prod_unlock_mask_i;
  logic                             soc_dft_en_o;
  logic                             soc_hw_debug_en_o;
  logic                             debug_locked_o;
  sec_state_pkg::device_lifecycle_e device_lifecycle_o;
  int unsigned                      error_count;
  int unsigned                      check_count;
  int unsigned                      cycle_cnt;
  int                               idx;
  int unsigned                      bit_sel;

  always #2 clk_i = ~clk_i;

  lcc_st_trans dut_i (.*);

  tb_lcc_checker checker_i (
    .*,
    .soc_dft_en_i       (soc_dft_en_o),
    .soc_hw_debug_en_i  (soc_hw_debug_en_o),
    .device_lifecycle_i (device_lifecycle_o),
    .debug_locked_i     (debug_locked_o),
    .error_count_o      (error_count),
    .check_count_o      (check_count)
  );

  // ------------------------------------------------------------
  // Stimulus helpers, all called on a falling edge
  // ------------------------------------------------------------

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic quiet_inputs();
    lcc_prog_req_i    = 1'b0;
    lcc_alive_state_i = lc_state_pkg::RAW;
    state_error_i     = 1'b0;
    dbg_manuf_en_i    = 1'b0;
    unlock_level_i    = '0;
    lc_dft_en_i       = 4'h0;
    lc_hw_debug_en_i  = 4'h0;
  endtask

  // Valid low for two cycles, then high until the state has settled
  task automatic bring_up(input lc_state_pkg::lc_state_e st);
    otp_valid_i = 1'b0;
    quiet_inputs();
    otp_state_i = st;
    wait_cycles(2);
    otp_valid_i = 1'b1;
    wait_cycles(5);
  endtask

  // Unlock where needed, escape for three cycles, then watch it stay locked
  task automatic escape_case(input lc_state_pkg::lc_state_e st, input logic by_scrap);
    bring_up(st);
    dbg_manuf_en_i = (st == lc_state_pkg::DEV);
    unlock_level_i = (st == lc_state_pkg::PROD) ? prod_unlock_mask_i : '0;
    wait_cycles(4);
    if (by_scrap) begin
      lcc_prog_req_i    = 1'b1;
      lcc_alive_state_i = lc_state_pkg::SCRAP;
    end else begin
      state_error_i = 1'b1;
    end
    wait_cycles(3);
    lcc_prog_req_i    = 1'b0;
    lcc_alive_state_i = lc_state_pkg::RAW;
    state_error_i     = 1'b0;
    wait_cycles(4);
  endtask

  function automatic sec_state_pkg::unlock_vec_t random_vec();
    return {$urandom(), $urandom()};
  endfunction

  // Half of the draws are the exact on value
  function automatic lc_state_pkg::lc_tx_t random_flag();
    if ($urandom_range(1, 0) == 1) begin
      return `LCC_TX_ON;
    end
    return lc_state_pkg::lc_tx_t'($urandom_range(15, 0));
  endfunction

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(32'h33d0));
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    otp_valid_i        = 1'b0;
    otp_state_i        = lc_state_pkg::RAW;
    dft_mask_i         = '0;
    cltap_mask_i       = '0;
    prod_unlock_mask_i = '0;
    quiet_inputs();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // Every state code with the unlock inputs quiet
    for (idx = 0; idx <= 20; idx++) begin
      bring_up(lc_state_pkg::lc_state_e'(5'(idx)));
    end

    // Manufacturing unlock, stays unlocked after the enable drops
    bring_up(lc_state_pkg::DEV);
    dbg_manuf_en_i = 1'b1;
    wait_cycles(4);
    dbg_manuf_en_i = 1'b0;
    wait_cycles(2);

    // Production unlock, a level with no overlap first
    repeat (4) begin
      bit_sel            = $urandom_range(63, 0);
      prod_unlock_mask_i = random_vec() | (64'd1 << bit_sel);
      bring_up(lc_state_pkg::PROD);
      unlock_level_i = ~prod_unlock_mask_i;
      wait_cycles(4);
      unlock_level_i = random_vec() | (64'd1 << bit_sel);
      wait_cycles(4);
    end

    // Enables with random flags, sparse masks and SCRAP requests
    bring_up(lc_state_pkg::RAW);
    repeat (40) begin
      dft_mask_i        = 64'd1 << $urandom_range(63, 0);
      cltap_mask_i      = 64'd1 << $urandom_range(63, 0);
      unlock_level_i    = random_vec() & random_vec() & random_vec();
      lc_dft_en_i       = random_flag();
      lc_hw_debug_en_i  = random_flag();
      lcc_prog_req_i    = ($urandom_range(3, 0) == 0);
      lcc_alive_state_i = ($urandom_range(1, 0) == 1) ? lc_state_pkg::SCRAP : lc_state_pkg::DEV;
      wait_cycles(2);
    end

    // Escape from each debug state, by SCRAP request and by state error
    prod_unlock_mask_i = 64'h0000_0040_0000_0000;
    for (idx = 0; idx < 2; idx++) begin
      escape_case(lc_state_pkg::TEST_UNLOCKED3, idx == 0);
      escape_case(lc_state_pkg::RMA, idx == 0);
      escape_case(lc_state_pkg::DEV, idx == 0);
      escape_case(lc_state_pkg::PROD, idx == 0);
    end

    // Valid drop from an unlocked state with the DFT flag on
    bring_up(lc_state_pkg::TEST_UNLOCKED0);
    lc_dft_en_i = `LCC_TX_ON;
    wait_cycles(2);
    otp_valid_i = 1'b0;
    wait_cycles(3);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Simulation completed successfully");
    end else begin
      if (check_count == 0) begin
        $display("No comparisons were made by the checker");
      end
      $display("Simulation failed");
    end
    $finish;
  end

  // Cycle limit in case a test never finishes
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
lc_state_pkg.sv
sec_state_pkg.sv
lc_class_decode.sv
lcc_debug_enables.sv
lcc_trans_fsm.sv
lcc_st_trans.sv
tb_lcc_checker.sv
tb_lcc_st_trans.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and pass only if the success line shows up
verilator --binary --timing -j 0 --top-module tb_lcc_st_trans -f build.f -o sim_lcc \
  && ./obj_dir/sim_lcc | tee /dev/stderr \
  | grep "Simulation completed successfully" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
